// File: logic/mem_macros.svh
`ifndef MEM_MACROS_SVH
`define MEM_MACROS_SVH

// Requesters sharing the memory
`define MEM_NUM_PORTS 4

// Words per line, equal to the bank count
`define MEM_LANES 4

// Word address width
`define MEM_ADDR_BITS 8

`endif

// File: logic/port_pkg.sv
`include "mem_macros.svh"

package port_pkg;

    typedef logic [`MEM_ADDR_BITS-1:0] mem_word_addr_t;

    // Lane k in bits 32k+31:32k
    typedef logic [`MEM_LANES*32-1:0] mem_line_t;

    typedef logic [$clog2(`MEM_NUM_PORTS)-1:0] mem_port_id_t;

    // Read data back to a requester, tagged with its port
    typedef struct packed {
        mem_port_id_t port;
        mem_line_t    line;
    } rt_resp_t;

    typedef struct packed {
        mem_line_t line;
    } mc_resp_t;

endpackage

// File: logic/bank_pkg.sv
`include "mem_macros.svh"

package bank_pkg;

    // Row inside one bank from the word address above its bank bits
    typedef logic [`MEM_ADDR_BITS-3:0] bank_row_t;

    typedef logic [31:0] bank_word_t;

    // Bank index, lane index, or start offset of a line
    typedef logic [$clog2(`MEM_LANES)-1:0] lane_sel_t;

endpackage

// File: logic/lane_rotator.sv
`include "mem_macros.svh"

module lane_rotator
    import port_pkg::*;
    import bank_pkg::*;
(
    input  mem_word_addr_t acc_addr,
    input  mem_line_t      acc_wdata,
    input  logic           acc_we,
    input  logic           clear_en,
    input  bank_row_t      clear_row,
    input  lane_sel_t      rd_offset,
    output bank_row_t      bank_row   [`MEM_LANES],
    output logic           bank_we    [`MEM_LANES],
    output bank_word_t     bank_wdata [`MEM_LANES],
    input  bank_word_t     bank_rdata [`MEM_LANES],
    output mem_line_t      rd_line
);

    lane_sel_t start_lane;

    assign start_lane = acc_addr[$bits(lane_sel_t)-1:0];

    for (genvar b = 0; b < `MEM_LANES; b++) begin : g_bank
        lane_sel_t      lane;       // Line lane that lands in this bank
        mem_word_addr_t word_addr;
        lane_sel_t      rd_bank;

        assign lane      = lane_sel_t'(b) - start_lane;
        assign word_addr = acc_addr + mem_word_addr_t'(lane); // Wraps at the top of memory

        // Clear sweep takes every bank over
        always_comb begin
            if (clear_en) begin
                bank_row[b]   = clear_row;
                bank_we[b]    = 1'b1;
                bank_wdata[b] = '0;
            end else begin
                bank_row[b]   = word_addr[`MEM_ADDR_BITS-1:$bits(lane_sel_t)];
                bank_we[b]    = acc_we;
                bank_wdata[b] = acc_wdata[lane*$bits(bank_word_t) +: $bits(bank_word_t)];
            end
        end

        // Lane b of the read line comes from bank (offset + b)
        assign rd_bank = rd_offset + lane_sel_t'(b);
        assign rd_line[b*$bits(bank_word_t) +: $bits(bank_word_t)] = bank_rdata[rd_bank];
    end

endmodule

// File: logic/bank_array.sv
`include "mem_macros.svh"

module bank_array
    import bank_pkg::*;
(
    input  logic       clk,
    input  bank_row_t  bank_row   [`MEM_LANES],
    input  logic       bank_we    [`MEM_LANES],
    input  bank_word_t bank_wdata [`MEM_LANES],
    output bank_word_t bank_rdata [`MEM_LANES]
);

    localparam int ROWS = 2 ** (`MEM_ADDR_BITS - 2);

    for (genvar b = 0; b < `MEM_LANES; b++) begin : g_ram
        bank_word_t mem [ROWS];
        bank_word_t q;

        // Read first, so a write in the same cycle returns the old word
        always_ff @(posedge clk) begin
            if (bank_we[b]) begin
                mem[bank_row[b]] <= bank_wdata[b];
            end
            q <= mem[bank_row[b]];
        end

        assign bank_rdata[b] = q;
    end

endmodule

// File: logic/clear_counter.sv
module clear_counter
    import bank_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  logic      step,
    output bank_row_t clear_row,
    output logic      clear_last
);

    bank_row_t row_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            row_q <= '0;
        end else if (step) begin
            row_q <= row_q + 1'b1; // Wraps back to row 0 after the sweep
        end
    end

    assign clear_row  = row_q;
    assign clear_last = &row_q;

endmodule

// File: logic/resp_slot.sv
module resp_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     load,
    input  payload_t load_data,
    output logic     full,
    output logic     out_valid,
    output payload_t out_data,
    input  logic     out_ready
);

    logic     valid_q;
    payload_t data_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else if (load) begin
            valid_q <= 1'b1;
        end else if (out_ready) begin
            valid_q <= 1'b0; // Handshake drains the entry
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            data_q <= load_data;
        end
    end

    assign out_valid = valid_q;
    assign out_data  = data_q;
    assign full      = valid_q;

endmodule

// File: logic/access_fsm.sv
`include "mem_macros.svh"

module access_fsm
    import port_pkg::*;
    import bank_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`MEM_NUM_PORTS-1:0] rt_valid,
    input  logic [`MEM_NUM_PORTS-1:0] rt_write,
    input  mem_word_addr_t            rt_addr  [`MEM_NUM_PORTS],
    input  mem_line_t                 rt_wdata [`MEM_NUM_PORTS],
    input  logic                      mc_valid,
    input  mem_word_addr_t            mc_addr,
    output logic [`MEM_NUM_PORTS-1:0] rt_ready,
    output logic                      mc_ready,
    input  logic                      rt_slot_full,
    input  logic                      mc_slot_full,
    input  logic                      clear_last,
    output logic                      cnt_step,
    output mem_word_addr_t            acc_addr,
    output mem_line_t                 acc_wdata,
    output logic                      acc_we,
    output logic                      clear_en,
    output lane_sel_t                 rd_offset,
    output logic                      cap_rt,
    output logic                      cap_mc,
    output mem_port_id_t              cap_port
);

    typedef enum logic [1:0] {
        CLEAR,
        IDLE,
        CAPTURE
    } state_t;

    state_t                    state, state_next;
    logic [`MEM_NUM_PORTS-1:0] rt_elig;
    logic                      mc_elig;
    logic [`MEM_NUM_PORTS-1:0] gnt_rt;
    logic                      gnt_mc;
    mem_port_id_t              rr_last;
    mem_port_id_t              win;
    logic                      win_found;
    logic                      pending;
    logic                      rd_hs;
    logic                      tgt_mc;

    assign pending = (state == CAPTURE); // Read data sits on the bank outputs

    // Reads need a free slot and no capture in progress; writes only need the memory up
    assign mc_elig = (state != CLEAR) && mc_valid && !mc_slot_full && !pending;

    for (genvar i = 0; i < `MEM_NUM_PORTS; i++) begin : g_elig
        assign rt_elig[i] = (state != CLEAR) && rt_valid[i]
                            && (rt_write[i] || (!rt_slot_full && !pending));
    end

    // Round robin starting after the last requester served
    always_comb begin : rr_pick
        mem_port_id_t idx;
        win       = rr_last;
        win_found = 1'b0;
        for (int n = 1; n <= `MEM_NUM_PORTS; n++) begin
            idx = rr_last + mem_port_id_t'(n);
            if (!win_found && rt_elig[idx]) begin
                win       = idx;
                win_found = 1'b1;
            end
        end
    end

    always_comb begin
        gnt_mc = mc_elig; // Controller always goes first
        gnt_rt = '0;
        if (!mc_elig && win_found) begin
            gnt_rt[win] = 1'b1;
        end
    end

    assign rt_ready  = gnt_rt;
    assign mc_ready  = gnt_mc;
    assign acc_addr  = gnt_mc ? mc_addr : rt_addr[win];
    assign acc_wdata = rt_wdata[win];
    assign acc_we    = |(gnt_rt & rt_write);
    assign rd_hs     = gnt_mc || (|(gnt_rt & ~rt_write));

    always_comb begin
        state_next = state;
        case (state)
            CLEAR:   if (clear_last) state_next = IDLE;
            IDLE:    if (rd_hs) state_next = CAPTURE;
            CAPTURE: state_next = IDLE;
            default: state_next = CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= CLEAR;
            rr_last <= mem_port_id_t'(`MEM_NUM_PORTS - 1); // Port 0 wins the first round
            tgt_mc  <= 1'b0;
        end else begin
            state <= state_next;
            if (|gnt_rt) begin
                rr_last <= win;
            end
            if (rd_hs) begin
                tgt_mc <= gnt_mc;
            end
        end
    end

    // Needed one cycle later to reorder and tag the read line
    always_ff @(posedge clk) begin
        if (rd_hs) begin
            rd_offset <= acc_addr[$bits(lane_sel_t)-1:0];
            cap_port  <= win;
        end
    end

    assign cap_rt   = pending && !tgt_mc;
    assign cap_mc   = pending && tgt_mc;
    assign clear_en = (state == CLEAR);
    assign cnt_step = clear_en;

endmodule

// File: logic/main_mem.sv
`include "mem_macros.svh"

module main_mem
    import port_pkg::*;
    import bank_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic [`MEM_NUM_PORTS-1:0] rt_valid,
    input  logic [`MEM_NUM_PORTS-1:0] rt_write,
    input  mem_word_addr_t            rt_addr  [`MEM_NUM_PORTS],
    input  mem_line_t                 rt_wdata [`MEM_NUM_PORTS],
    output logic [`MEM_NUM_PORTS-1:0] rt_ready,
    input  logic                      rt_resp_ready,
    output logic                      rt_resp_valid,
    output mem_port_id_t              rt_resp_port,
    output mem_line_t                 rt_resp_data,
    input  logic                      mc_valid,
    input  mem_word_addr_t            mc_addr,
    output logic                      mc_ready,
    input  logic                      mc_resp_ready,
    output logic                      mc_resp_valid,
    output mem_line_t                 mc_resp_data
);

    logic           rt_slot_full;
    logic           mc_slot_full;
    logic           clear_last;
    logic           cnt_step;
    logic           clear_en;
    bank_row_t      clear_row;
    mem_word_addr_t acc_addr;
    mem_line_t      acc_wdata;
    logic           acc_we;
    lane_sel_t      rd_offset;
    logic           cap_rt;
    logic           cap_mc;
    mem_port_id_t   cap_port;
    mem_line_t      rd_line;
    bank_row_t      bank_row   [`MEM_LANES];
    logic           bank_we    [`MEM_LANES];
    bank_word_t     bank_wdata [`MEM_LANES];
    bank_word_t     bank_rdata [`MEM_LANES];
    rt_resp_t       rt_load;
    rt_resp_t       rt_out;
    mc_resp_t       mc_load;
    mc_resp_t       mc_out;

    access_fsm i_access_fsm (
        .clk, .rst_n,
        .rt_valid, .rt_write, .rt_addr, .rt_wdata,
        .mc_valid, .mc_addr,
        .rt_ready, .mc_ready,
        .rt_slot_full, .mc_slot_full, .clear_last,
        .cnt_step, .acc_addr, .acc_wdata, .acc_we, .clear_en,
        .rd_offset, .cap_rt, .cap_mc, .cap_port
    );

    clear_counter i_clear_counter (
        .clk, .rst_n,
        .step       (cnt_step),
        .clear_row,
        .clear_last
    );

    lane_rotator i_lane_rotator (
        .acc_addr, .acc_wdata, .acc_we, .clear_en, .clear_row, .rd_offset,
        .bank_row, .bank_we, .bank_wdata, .bank_rdata, .rd_line
    );

    bank_array i_bank_array (
        .clk, .bank_row, .bank_we, .bank_wdata, .bank_rdata
    );

    assign rt_load.port = cap_port;
    assign rt_load.line = rd_line;
    assign mc_load.line = rd_line;

    resp_slot #(.payload_t(rt_resp_t)) i_rt_slot (
        .clk, .rst_n,
        .load      (cap_rt),
        .load_data (rt_load),
        .full      (rt_slot_full),
        .out_valid (rt_resp_valid),
        .out_data  (rt_out),
        .out_ready (rt_resp_ready)
    );

    resp_slot #(.payload_t(mc_resp_t)) i_mc_slot (
        .clk, .rst_n,
        .load      (cap_mc),
        .load_data (mc_load),
        .full      (mc_slot_full),
        .out_valid (mc_resp_valid),
        .out_data  (mc_out),
        .out_ready (mc_resp_ready)
    );

    assign rt_resp_port = rt_out.port;
    assign rt_resp_data = rt_out.line;
    assign mc_resp_data = mc_out.line;

endmodule

// File: bench/main_mem_assert.sv
`include "mem_macros.svh"

module main_mem_assert
    import port_pkg::*;
(
    input logic                      clk,
    input logic                      rst_n,
    input logic [`MEM_NUM_PORTS-1:0] rt_ready,
    input logic                      mc_ready,
    input logic                      rt_resp_valid,
    input logic                      rt_resp_ready,
    input mem_port_id_t              rt_resp_port,
    input mem_line_t                 rt_resp_data,
    input logic                      mc_resp_valid,
    input logic                      mc_resp_ready,
    input mem_line_t                 mc_resp_data
);

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLEAR_CYCLES = 2 ** (`MEM_ADDR_BITS - 2);

    int unsigned up_cycles; // Edges seen since reset up to the end of the sweep
    int unsigned fail_count = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_cycles <= 0;
        end else if (up_cycles < CLEAR_CYCLES) begin
            up_cycles <= up_cycles + 1;
        end
    end

    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(rt_ready))
        else begin
            $error("rt_ready has more than one bit set");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        up_cycles < CLEAR_CYCLES |-> !mc_ready && rt_ready == '0)
        else begin
            $error("ready raised during the clear sweep");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) !(mc_ready && rt_ready != '0))
        else begin
            $error("controller and requester offered ready together");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) rt_resp_valid && !rt_resp_ready
        |=> rt_resp_valid && $stable(rt_resp_port) && $stable(rt_resp_data))
        else begin
            $error("requester response dropped or changed before acceptance");
            fail_count++;
        end

    assert property (@(posedge clk) disable iff (!rst_n) mc_resp_valid && !mc_resp_ready
        |=> mc_resp_valid && $stable(mc_resp_data))
        else begin
            $error("controller response dropped or changed before acceptance");
            fail_count++;
        end

endmodule

bind main_mem main_mem_assert i_main_mem_assert (.*);

// File: bench/main_mem_tb.sv
`include "mem_macros.svh"

module main_mem_tb
    import port_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLEAR_CYCLES = 2 ** (`MEM_ADDR_BITS - 2);
    localparam int READ_ONLY    = 300;  // Read-only phase with every line expected zero
    localparam int RUN_CYCLES   = 2500;
    localparam int WAIT_LIMIT   = 300;

    logic                      clk, rst_n;
    logic [`MEM_NUM_PORTS-1:0] rt_valid, rt_write, rt_ready;
    mem_word_addr_t            rt_addr  [`MEM_NUM_PORTS];
    mem_line_t                 rt_wdata [`MEM_NUM_PORTS];
    logic                      rt_resp_ready, rt_resp_valid;
    mem_port_id_t              rt_resp_port;
    mem_line_t                 rt_resp_data;
    logic                      mc_valid, mc_ready, mc_resp_ready, mc_resp_valid;
    mem_word_addr_t            mc_addr;
    mem_line_t                 mc_resp_data;

    logic [31:0]               model_mem [2 ** `MEM_ADDR_BITS];
    rt_resp_t                  rt_exp_q [$];
    mc_resp_t                  mc_exp_q [$];
    logic [`MEM_NUM_PORTS-1:0] hs_rt;
    logic                      hs_mc, rd_last, stim_on, allow_write;
    int                        cyc, rt_rd_cyc, mc_rd_cyc, mc_wait;
    int                        wait_cnt    [`MEM_NUM_PORTS];
    int                        passed_over [`MEM_NUM_PORTS];

    main_mem i_main_mem (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic end_with_failure();
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_bound_asserts();
        if (i_main_mem.i_main_mem_assert.fail_count != 0) begin
            $display("%0t ns: an assertion on the DUT ports failed", $time);
            end_with_failure();
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s got %b expected %b", $time, name, got, exp);
            end_with_failure();
        end
    endtask

    task automatic check_rt_resp(input rt_resp_t got, input rt_resp_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns rt_resp_port/rt_resp_data got %0d/%h expected %0d/%h",
                     $time, got.port, got.line, exp.port, exp.line);
            end_with_failure();
        end
    endtask

    task automatic check_mc_resp(input mc_resp_t got, input mc_resp_t exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns mc_resp_data got %h expected %h", $time, got.line, exp.line);
            end_with_failure();
        end
    endtask

    // Word a+k of memory sits in lane k
    function automatic mem_line_t model_line(input mem_word_addr_t a);
        mem_line_t line;
        for (int k = 0; k < `MEM_LANES; k++) begin
            line[32*k +: 32] = model_mem[mem_word_addr_t'(a + k)];
        end
        return line;
    endfunction

    function automatic mem_word_addr_t pick_addr();
        if ($urandom_range(1, 0) == 1) begin
            return '1 - mem_word_addr_t'($urandom_range(7, 0)); // Near the top so lines wrap
        end
        return mem_word_addr_t'($urandom);
    endfunction

    function automatic logic all_idle();
        return rt_valid == '0 && !mc_valid && rt_exp_q.size() == 0 && mc_exp_q.size() == 0;
    endfunction

    // Looks at the handshakes that the next rising edge will take
    task automatic observe_edge();
        rt_resp_t rt_got;
        mc_resp_t mc_got;
        @(negedge clk);
        check_bound_asserts();
        cyc++;
        hs_rt = rt_valid & rt_ready;
        hs_mc = mc_valid && mc_ready;
        if (cyc == rt_rd_cyc + 1 || cyc == rt_rd_cyc + 2) begin
            check_flag("rt_resp_valid", rt_resp_valid, cyc == rt_rd_cyc + 2);
        end
        if (cyc == mc_rd_cyc + 1 || cyc == mc_rd_cyc + 2) begin
            check_flag("mc_resp_valid", mc_resp_valid, cyc == mc_rd_cyc + 2);
        end
        rt_got.port = rt_resp_port;
        rt_got.line = rt_resp_data;
        mc_got.line = mc_resp_data;
        if (rt_resp_valid && rt_resp_ready) begin
            if (rt_exp_q.size() == 0) begin
                $display("%0t ns: requester response with no read outstanding", $time);
                end_with_failure();
            end else begin
                check_rt_resp(rt_got, rt_exp_q.pop_front());
            end
        end
        if (mc_resp_valid && mc_resp_ready) begin
            if (mc_exp_q.size() == 0) begin
                $display("%0t ns: controller response with no read outstanding", $time);
                end_with_failure();
            end else begin
                check_mc_resp(mc_got, mc_exp_q.pop_front());
            end
        end
        if (cyc > CLEAR_CYCLES && mc_valid && !mc_resp_valid && !rd_last) begin
            check_flag("mc_ready", mc_ready, 1'b1); // Controller goes ahead of requesters
        end
        if (hs_mc) begin
            mc_exp_q.push_back(mc_resp_t'(model_line(mc_addr)));
            mc_rd_cyc = cyc;
        end
        for (int i = 0; i < `MEM_NUM_PORTS; i++) begin
            if (hs_rt[i] && rt_write[i]) begin
                for (int k = 0; k < `MEM_LANES; k++) begin
                    model_mem[mem_word_addr_t'(rt_addr[i] + k)] = rt_wdata[i][32*k +: 32];
                end
            end else if (hs_rt[i]) begin
                rt_exp_q.push_back(rt_resp_t'({mem_port_id_t'(i), model_line(rt_addr[i])}));
                rt_rd_cyc = cyc;
            end
        end
        rd_last = hs_mc || (hs_rt & ~rt_write) != '0;
        for (int i = 0; i < `MEM_NUM_PORTS; i++) begin
            if (rt_valid[i] && !hs_rt[i]) begin
                wait_cnt[i]++;
                if (rt_write[i] && hs_rt != '0) begin
                    passed_over[i]++; // Only round robin can hold back a write
                end
            end else begin
                wait_cnt[i]    = 0;
                passed_over[i] = 0;
            end
            if (passed_over[i] > `MEM_NUM_PORTS || wait_cnt[i] > WAIT_LIMIT) begin
                $display("%0t ns: requester %0d kept waiting, %0d cycles and %0d other grants",
                         $time, i, wait_cnt[i], passed_over[i]);
                end_with_failure();
            end
        end
        mc_wait = (mc_valid && !hs_mc) ? mc_wait + 1 : 0;
        if (mc_wait > WAIT_LIMIT) begin
            $display("%0t ns: controller read was not accepted in time", $time);
            end_with_failure();
        end
    endtask

    task automatic drive_inputs();
        @(posedge clk);
        #1;
        for (int i = 0; i < `MEM_NUM_PORTS; i++) begin
            if (hs_rt[i]) begin
                rt_valid[i] = 1'b0;
            end
            if (!rt_valid[i] && stim_on && $urandom_range(2, 0) == 0) begin
                rt_valid[i] = 1'b1;
                rt_write[i] = allow_write && ($urandom_range(1, 0) == 1);
                rt_addr[i]  = pick_addr();
                rt_wdata[i] = {$urandom, $urandom, $urandom, $urandom};
            end
        end
        if (hs_mc) begin
            mc_valid = 1'b0;
        end
        if (!mc_valid && stim_on && $urandom_range(3, 0) == 0) begin
            mc_valid = 1'b1;
            mc_addr  = pick_addr();
        end
        rt_resp_ready = ($urandom_range(3, 0) != 0); // Back-pressure about one cycle in four
        mc_resp_ready = ($urandom_range(3, 0) != 0);
    endtask

    initial begin
        void'($urandom(51));
        rst_n         = 1'b0;
        rt_valid      = '0;
        rt_write      = '0;
        mc_valid      = 1'b0;
        mc_addr       = '0;
        rt_resp_ready = 1'b0;
        mc_resp_ready = 1'b0;
        hs_rt         = '0;
        hs_mc         = 1'b0;
        rd_last       = 1'b0;
        stim_on       = 1'b1;
        allow_write   = 1'b0;
        cyc           = 0;
        rt_rd_cyc     = -10;
        mc_rd_cyc     = -10;
        mc_wait       = 0;
        for (int i = 0; i < `MEM_NUM_PORTS; i++) begin
            rt_addr[i]     = '0;
            rt_wdata[i]    = '0;
            wait_cnt[i]    = 0;
            passed_over[i] = 0;
        end
        foreach (model_mem[w]) begin
            model_mem[w] = '0; // Contents after the clear sweep
        end
        repeat (8) @(posedge clk);
        #1 rst_n = 1'b1;
        for (int n = 0; n < RUN_CYCLES; n++) begin
            allow_write = (n >= READ_ONLY);
            observe_edge();
            drive_inputs();
        end
        stim_on = 1'b0;
        for (int n = 0; n < WAIT_LIMIT && !all_idle(); n++) begin
            observe_edge();
            drive_inputs();
        end
        check_bound_asserts();
        if (!all_idle()) begin
            $display("%0t ns: requests or responses still outstanding after the drain", $time);
            end_with_failure();
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

// File: vlog.f
+incdir+logic
logic/port_pkg.sv
logic/bank_pkg.sv
logic/lane_rotator.sv
logic/bank_array.sv
logic/clear_counter.sv
logic/resp_slot.sv
logic/access_fsm.sv
logic/main_mem.sv
bench/main_mem_assert.sv
bench/main_mem_tb.sv
